//--- all.f
verilog/eth_rx_pkg.sv
verilog/stream_skid.sv
verilog/frame_distributor.sv
verilog/eth_hdr_parser.sv
verilog/frame_merger.sv
verilog/rx_apb_regs.sv
verilog/eth_rx_array.sv
tests/tb_eth_rx_array.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_eth_rx_array -f all.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
grep -q "TEST PASS" sim.log

//--- tests/tb_eth_rx_array.sv
`timescale 1ns/10ps

module tb_eth_rx_array;

    import eth_rx_pkg::*;

    localparam int wait_limit = 2000;
    localparam int run_limit  = 50000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    axis_beat_t  in_beat;
    logic        in_valid;
    logic        in_ready;
    eth_hdr_t    out_hdr;
    logic        out_hdr_valid;
    logic        out_hdr_ready;
    axis_beat_t  out_beat;
    logic        out_valid;
    logic        out_ready = 1'b1;

    // expected headers and shifted payload beats, in sending order
    eth_hdr_t    hdr_q [$];
    axis_beat_t  beat_q [$];
    logic [7:0]  frame_bytes [80];
    logic        frame_user;
    int          align_len [8] = '{15, 16, 22, 23, 24, 25, 39, 40};
    logic [15:0] lfsr;
    logic [15:0] stall_lfsr = 16'd5;
    logic        stall_en;
    logic        hung;
    logic        run_done;
    int          errors;
    int          tests;
    int          test_base;
    int          good_sent;
    int          runts_sent;
    int          frames_sent;

    // output transfers captured at the rising edge
    logic        hdr_fire;
    logic        hdr_have;
    eth_hdr_t    got_hdr;
    eth_hdr_t    exp_hdr;
    logic        beat_fire;
    logic        beat_have;
    axis_beat_t  got_beat;
    axis_beat_t  exp_beat;

    eth_rx_array eth_rx_array_i (
        .clk           (clk),
        .rst           (rst),
        .psel          (psel),
        .penable       (penable),
        .pwrite        (pwrite),
        .paddr         (paddr),
        .pwdata        (pwdata),
        .prdata        (prdata),
        .pready        (pready),
        .pslverr       (pslverr),
        .in_beat       (in_beat),
        .in_valid      (in_valid),
        .in_ready      (in_ready),
        .out_hdr       (out_hdr),
        .out_hdr_valid (out_hdr_valid),
        .out_hdr_ready (out_hdr_ready),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int good_len();
        return 14 + rand_bits(7) % 67;
    endfunction

    function automatic logic [63:0] keep_mask(input logic [7:0] keep);
        logic [63:0] m;
        for (int j = 0; j < 8; j++) begin
            m[8*j +: 8] = {8{keep[j]}};
        end
        return m;
    endfunction

    // up to 8 frame bytes from start, byte start in data[7:0]
    function automatic axis_beat_t pack_beat(input int start, input int len);
        axis_beat_t b;
        b = '0;
        for (int j = 0; j < 8; j++) begin
            if (start + j < len) begin
                b.data[8*j +: 8] = frame_bytes[start + j];
                b.keep[j]        = 1'b1;
            end
        end
        b.last = (start + 8 >= len);
        b.user = frame_user;
        return b;
    endfunction

    task automatic stuck(input string why);
        $display("timeout: %s", why);
        hung = 1'b1;
        forever @(posedge clk);
    endtask

    task automatic build_frame(input int len);
        eth_hdr_t h;
        int       nb;
        frame_user = 1'(rand_bits(1));
        for (int i = 0; i < len; i++) begin
            frame_bytes[i] = 8'(rand_bits(8));
        end
        frames_sent++;
        if (len < 14) begin
            runts_sent++;
        end else begin
            // network order, first byte in the top bits
            for (int i = 0; i < 6; i++) begin
                h.dest_mac[47-8*i -: 8] = frame_bytes[i];
                h.src_mac[47-8*i -: 8]  = frame_bytes[6 + i];
            end
            h.eth_type = {frame_bytes[12], frame_bytes[13]};
            hdr_q.push_back(h);
            // a bare header still yields one empty closing beat
            nb = (len == 14) ? 1 : (len - 14 + 7) / 8;
            for (int k = 0; k < nb; k++) begin
                beat_q.push_back(pack_beat(14 + 8*k, len));
            end
            good_sent++;
        end
    endtask

    task automatic put_beat(input axis_beat_t b);
        int n;
        in_beat  = b;
        in_valid = 1'b1;
        n = 0;
        while (!in_ready) begin
            if (n == wait_limit) begin
                stuck("the input stream never became ready");
            end
            @(negedge clk);
            n++;
        end
        @(negedge clk);
    endtask

    task automatic drive_frame(input int len, input int first_beat);
        for (int k = first_beat; k < (len + 7) / 8; k++) begin
            put_beat(pack_beat(8*k, len));
        end
        in_valid = 1'b0;
        in_beat  = '0;
    endtask

    task automatic send_frame(input int len);
        build_frame(len);
        drive_frame(len, 0);
    endtask

    task automatic drain();
        int n;
        n = 0;
        while (hdr_q.size() != 0 || beat_q.size() != 0) begin
            if (n == wait_limit) begin
                stuck("expected frames never left the output");
            end
            @(negedge clk);
            n++;
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic wait_pready();
        int n;
        #1;
        n = 0;
        while (!pready) begin
            if (n == wait_limit) begin
                stuck("pready never rose in the access phase");
            end
            @(negedge clk);
            #1;
            n++;
        end
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;
        wait_pready();
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic read_reg(input logic [7:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        wait_pready();
        data = prdata;
        err  = pslverr;
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_reg(input string name, input logic [7:0] addr,
                             input logic [31:0] exp);
        logic [31:0] got;
        logic        err;
        read_reg(addr, got, err);
        assert (got == exp) else begin
            errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s finished with %0d errors", tests, name, errors - test_base);
        test_base = errors;
    endtask

    // random back-pressure on the payload output
    always @(negedge clk) begin
        if (stall_en) begin
            stall_lfsr <= lfsr_next(stall_lfsr);
            out_ready  <= stall_lfsr[0];
        end else begin
            out_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        hdr_fire  <= out_hdr_valid && out_hdr_ready && !rst;
        beat_fire <= out_valid && out_ready && !rst;
        if (out_hdr_valid && out_hdr_ready) begin
            got_hdr  <= out_hdr;
            hdr_have <= hdr_q.size() != 0;
            if (hdr_q.size() != 0) begin
                exp_hdr <= hdr_q.pop_front();
            end
        end
        if (out_valid && out_ready) begin
            got_beat  <= out_beat;
            beat_have <= beat_q.size() != 0;
            if (beat_q.size() != 0) begin
                exp_beat <= beat_q.pop_front();
            end
        end
    end

    hdr_seen_a: assert property (@(negedge clk) disable iff (rst) hdr_fire |-> hdr_have)
        else begin
            errors++;
            $display("a header left out_hdr while no frame was outstanding");
        end

    hdr_value_a: assert property (@(negedge clk) disable iff (rst)
        hdr_fire && hdr_have |-> got_hdr == exp_hdr)
        else begin
            errors++;
            $display("error out_hdr got %h expected %h", got_hdr, exp_hdr);
        end

    beat_seen_a: assert property (@(negedge clk) disable iff (rst) beat_fire |-> beat_have)
        else begin
            errors++;
            $display("a payload beat left the output while none was outstanding");
        end

    beat_keep_a: assert property (@(negedge clk) disable iff (rst)
        beat_fire && beat_have |-> got_beat.keep == exp_beat.keep)
        else begin
            errors++;
            $display("error out_beat.keep got %h expected %h", got_beat.keep, exp_beat.keep);
        end

    beat_last_a: assert property (@(negedge clk) disable iff (rst)
        beat_fire && beat_have |-> got_beat.last == exp_beat.last)
        else begin
            errors++;
            $display("error out_beat.last got %h expected %h", got_beat.last, exp_beat.last);
        end

    beat_user_a: assert property (@(negedge clk) disable iff (rst)
        beat_fire && beat_have |-> got_beat.user == exp_beat.user)
        else begin
            errors++;
            $display("error out_beat.user got %h expected %h", got_beat.user, exp_beat.user);
        end

    // only bytes with keep set carry payload
    beat_data_a: assert property (@(negedge clk) disable iff (rst)
        beat_fire && beat_have |->
        (got_beat.data & keep_mask(exp_beat.keep)) == exp_beat.data)
        else begin
            errors++;
            $display("error out_beat.data got %h expected %h",
                     got_beat.data & keep_mask(exp_beat.keep), exp_beat.data);
        end

    initial begin
        logic [31:0] rd;
        logic        err;
        int          busy_lane;
        lfsr          = 16'd5;
        rst           = 1'b1;
        psel          = 1'b0;
        penable       = 1'b0;
        pwrite        = 1'b0;
        paddr         = '0;
        pwdata        = '0;
        in_beat       = '0;
        in_valid      = 1'b0;
        out_hdr_ready = 1'b1;
        stall_en      = 1'b0;
        hung          = 1'b0;
        run_done      = 1'b0;
        errors        = 0;
        tests         = 0;
        test_base     = 0;
        good_sent     = 0;
        runts_sent    = 0;
        frames_sent   = 0;
        repeat (4) @(negedge clk);
        rst = 1'b0;

        assert (!in_ready && !out_valid && !out_hdr_valid) else begin
            errors++;
            $display("in_ready, out_valid or out_hdr_valid was high right after reset");
        end
        check_reg("reg_ctrl", reg_ctrl, 32'd0);
        write_reg(reg_ctrl, 32'd1);
        check_reg("reg_ctrl", reg_ctrl, 32'd1);
        write_reg(reg_ctrl, 32'd0);
        check_reg("reg_ctrl", reg_ctrl, 32'd0);
        read_reg(8'h10, rd, err);
        assert (err) else begin
            errors++;
            $display("error pslverr got %h expected %h", err, 1'b1);
        end
        write_reg(reg_ctrl, 32'd1);
        write_reg(reg_frames, 32'd0);
        end_test("reset and apb");

        send_frame(14);
        send_frame(80);
        for (int i = 0; i < 4; i++) begin
            send_frame(good_len());
        end
        drain();
        end_test("header decode");

        // closing beats with and without keep bits 7:6
        for (int i = 0; i < 8; i++) begin
            send_frame(align_len[i]);
        end
        drain();
        end_test("payload alignment");

        stall_en = 1'b1;
        for (int i = 0; i < 12; i++) begin
            send_frame(good_len());
        end
        drain();
        stall_en = 1'b0;
        end_test("order and back-pressure");

        write_reg(reg_runts, 32'd0);
        runts_sent = 0;
        for (int i = 0; i < 13; i++) begin
            if (i % 2 == 0) begin
                send_frame(good_len());
            end else if (i == 1) begin
                send_frame(13);
            end else if (i == 3) begin
                send_frame(8);
            end else if (i == 5) begin
                send_frame(9);
            end else begin
                send_frame(1 + rand_bits(4) % 13);
            end
        end
        drain();
        check_reg("reg_runts", reg_runts, 32'(runts_sent));
        end_test("runt frames");

        check_reg("reg_frames", reg_frames, 32'(good_sent));
        write_reg(reg_frames, 32'd0);
        check_reg("reg_frames", reg_frames, 32'd0);
        write_reg(reg_ctrl, 32'd0);
        // first beat waits at the boundary while enable is clear
        build_frame(20);
        in_beat  = pack_beat(0, 20);
        in_valid = 1'b1;
        for (int i = 0; i < 16; i++) begin
            @(negedge clk);
            assert (!in_ready) else begin
                errors++;
                $display("error in_ready got %h expected %h", in_ready, 1'b0);
            end
        end
        write_reg(reg_ctrl, 32'd1);
        // lanes take frames in turn from lane 0, runts included
        put_beat(pack_beat(0, 20));
        in_valid  = 1'b0;
        busy_lane = (frames_sent - 1) % num_lanes;
        check_reg("reg_status", reg_status, 32'(1 << busy_lane));
        drive_frame(20, 1);
        drain();
        check_reg("reg_frames", reg_frames, 32'd1);
        check_reg("reg_status", reg_status, 32'd0);
        end_test("counting and enable");
        run_done = 1'b1;
    end

    initial begin
        int n;
        @(negedge clk);
        n = 0;
        while (!run_done && !hung) begin
            if (n == run_limit) begin
                $display("timeout: the test sequence never finished");
                hung = 1'b1;
            end else begin
                @(negedge clk);
                n++;
            end
        end
        $display("tests %0d, good frames %0d, runt frames %0d, errors %0d",
                 tests, good_sent, runts_sent, errors);
        if (hung || errors != 0) begin
            $display("TEST FAIL");
        end else begin
            $display("TEST PASS");
        end
        $finish;
    end

endmodule

//--- verilog/eth_rx_array.sv
`timescale 1ns/10ps

module eth_rx_array (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [7:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  eth_rx_pkg::axis_beat_t in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output eth_rx_pkg::eth_hdr_t   out_hdr,
    output logic                   out_hdr_valid,
    input  logic                   out_hdr_ready,
    output eth_rx_pkg::axis_beat_t out_beat,
    output logic                   out_valid,
    input  logic                   out_ready
);

    import eth_rx_pkg::*;

    axis_beat_t           dist_beat;
    logic [num_lanes-1:0] dist_valid;
    logic [num_lanes-1:0] dist_ready;
    eth_hdr_t             lane_hdr [num_lanes];
    logic [num_lanes-1:0] lane_hdr_valid;
    logic [num_lanes-1:0] lane_hdr_ready;
    axis_beat_t           lane_beat [num_lanes];
    logic [num_lanes-1:0] lane_valid;
    logic [num_lanes-1:0] lane_ready;
    logic [num_lanes-1:0] lane_runt;
    logic [num_lanes-1:0] lane_busy;
    logic                 frame_done;
    logic                 enable;

    frame_distributor dist_i (
        .clk        (clk),
        .rst        (rst),
        .enable     (enable),
        .in_beat    (in_beat),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .lane_beat  (dist_beat),
        .lane_valid (dist_valid),
        .lane_ready (dist_ready)
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        eth_hdr_parser parser_i (
            .clk       (clk),
            .rst       (rst),
            .in_beat   (dist_beat),
            .in_valid  (dist_valid[i]),
            .in_ready  (dist_ready[i]),
            .hdr       (lane_hdr[i]),
            .hdr_valid (lane_hdr_valid[i]),
            .hdr_ready (lane_hdr_ready[i]),
            .pay_beat  (lane_beat[i]),
            .pay_valid (lane_valid[i]),
            .pay_ready (lane_ready[i]),
            .runt      (lane_runt[i]),
            .busy      (lane_busy[i])
        );
    end

    frame_merger merger_i (
        .clk            (clk),
        .rst            (rst),
        .lane_hdr       (lane_hdr),
        .lane_hdr_valid (lane_hdr_valid),
        .lane_hdr_ready (lane_hdr_ready),
        .lane_beat      (lane_beat),
        .lane_valid     (lane_valid),
        .lane_ready     (lane_ready),
        .lane_runt      (lane_runt),
        .out_hdr        (out_hdr),
        .out_hdr_valid  (out_hdr_valid),
        .out_hdr_ready  (out_hdr_ready),
        .out_beat       (out_beat),
        .out_valid      (out_valid),
        .out_ready      (out_ready),
        .frame_done     (frame_done)
    );

    rx_apb_regs regs_i (
        .clk        (clk),
        .rst        (rst),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .frame_done (frame_done),
        .runt       (lane_runt),
        .busy       (lane_busy),
        .enable     (enable)
    );

endmodule

//--- verilog/rx_apb_regs.sv
`timescale 1ns/10ps

module rx_apb_regs (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [7:0]                       paddr,
    input  logic [31:0]                      pwdata,
    output logic [31:0]                      prdata,
    output logic                             pready,
    output logic                             pslverr,
    input  logic                             frame_done,
    input  logic [eth_rx_pkg::num_lanes-1:0] runt,
    input  logic [eth_rx_pkg::num_lanes-1:0] busy,
    output logic                             enable
);

    import eth_rx_pkg::*;

    logic [31:0] frame_cnt;
    logic [31:0] runt_cnt;
    logic        access;
    logic        addr_ok;
    logic        wr;

    assign access  = psel && penable;
    assign addr_ok = paddr inside {reg_ctrl, reg_frames, reg_runts, reg_status};
    assign wr      = access && pwrite && addr_ok;
    assign pready  = 1'b1;
    assign pslverr = access && !addr_ok;

    always_comb begin
        case (paddr)
            reg_ctrl:   prdata = {31'd0, enable};
            reg_frames: prdata = frame_cnt;
            reg_runts:  prdata = runt_cnt;
            reg_status: prdata = 32'(busy);
            default:    prdata = '0;
        endcase
    end

    // counters saturate, any write clears
    always_ff @(posedge clk) begin
        if (rst) begin
            enable    <= 1'b0;
            frame_cnt <= '0;
            runt_cnt  <= '0;
        end else begin
            if (wr && paddr == reg_ctrl) begin
                enable <= pwdata[0];
            end
            if (wr && paddr == reg_frames) begin
                frame_cnt <= '0;
            end else if (frame_done && frame_cnt != '1) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
            if (wr && paddr == reg_runts) begin
                runt_cnt <= '0;
            end else if (|runt && runt_cnt != '1) begin
                runt_cnt <= runt_cnt + 1'b1;
            end
        end
    end

    apb_enable_a: assert property (@(posedge clk) disable iff (rst) penable |-> psel);

endmodule

//--- verilog/frame_merger.sv
`timescale 1ns/10ps

module frame_merger (
    input  logic                             clk,
    input  logic                             rst,
    input  eth_rx_pkg::eth_hdr_t             lane_hdr [eth_rx_pkg::num_lanes],
    input  logic [eth_rx_pkg::num_lanes-1:0] lane_hdr_valid,
    output logic [eth_rx_pkg::num_lanes-1:0] lane_hdr_ready,
    input  eth_rx_pkg::axis_beat_t           lane_beat [eth_rx_pkg::num_lanes],
    input  logic [eth_rx_pkg::num_lanes-1:0] lane_valid,
    output logic [eth_rx_pkg::num_lanes-1:0] lane_ready,
    input  logic [eth_rx_pkg::num_lanes-1:0] lane_runt,
    output eth_rx_pkg::eth_hdr_t             out_hdr,
    output logic                             out_hdr_valid,
    input  logic                             out_hdr_ready,
    output eth_rx_pkg::axis_beat_t           out_beat,
    output logic                             out_valid,
    input  logic                             out_ready,
    output logic                             frame_done
);

    import eth_rx_pkg::*;

    logic [lane_bits-1:0]     turn;
    logic                     pay_phase;
    logic [runt_cnt_bits-1:0] runt_cnt [num_lanes];
    logic [num_lanes-1:0]     runt_dec;
    logic                     skip;
    logic                     hdr_in_valid;
    logic                     hdr_in_ready;
    logic                     pay_in_valid;
    logic                     pay_in_ready;

    // a lane that owes a dropped frame gives up its turn
    assign skip         = !pay_phase && (runt_cnt[turn] != '0);
    assign hdr_in_valid = !pay_phase && !skip && lane_hdr_valid[turn];
    assign pay_in_valid = pay_phase && lane_valid[turn];
    assign frame_done   = out_hdr_valid && out_hdr_ready;

    always_comb begin
        lane_hdr_ready       = '0;
        lane_ready           = '0;
        runt_dec             = '0;
        lane_hdr_ready[turn] = hdr_in_ready && !pay_phase && !skip;
        lane_ready[turn]     = pay_in_ready && pay_phase;
        runt_dec[turn]       = skip;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            turn      <= '0;
            pay_phase <= 1'b0;
        end else if (skip) begin
            turn <= turn + 1'b1;
        end else if (hdr_in_valid && hdr_in_ready) begin
            pay_phase <= 1'b1;
        end else if (pay_in_valid && pay_in_ready && lane_beat[turn].last) begin
            pay_phase <= 1'b0;
            turn      <= turn + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < num_lanes; i++) begin
                runt_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < num_lanes; i++) begin
                if (lane_runt[i] != runt_dec[i]) begin
                    runt_cnt[i] <= lane_runt[i] ? runt_cnt[i] + 1'b1 : runt_cnt[i] - 1'b1;
                end
            end
        end
    end

    stream_skid #(
        .payload_t (eth_hdr_t)
    ) hdr_skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (lane_hdr[turn]),
        .in_valid  (hdr_in_valid),
        .in_ready  (hdr_in_ready),
        .out_data  (out_hdr),
        .out_valid (out_hdr_valid),
        .out_ready (out_hdr_ready)
    );

    stream_skid #(
        .payload_t (axis_beat_t)
    ) pay_skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (lane_beat[turn]),
        .in_valid  (pay_in_valid),
        .in_ready  (pay_in_ready),
        .out_data  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    for (genvar i = 0; i < num_lanes; i++) begin : g_runt_chk
        runt_wrap_a: assert property (@(posedge clk) disable iff (rst)
            lane_runt[i] && !runt_dec[i] |-> runt_cnt[i] != '1);
    end

endmodule

//--- verilog/eth_hdr_parser.sv
`timescale 1ns/10ps

module eth_hdr_parser (
    input  logic                   clk,
    input  logic                   rst,
    input  eth_rx_pkg::axis_beat_t in_beat,
    input  logic                   in_valid,
    output logic                   in_ready,
    output eth_rx_pkg::eth_hdr_t   hdr,
    output logic                   hdr_valid,
    input  logic                   hdr_ready,
    output eth_rx_pkg::axis_beat_t pay_beat,
    output logic                   pay_valid,
    input  logic                   pay_ready,
    output logic                   runt,
    output logic                   busy
);

    import eth_rx_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_hdr,
        st_pay
    } state_t;

    state_t     state;
    state_t     state_next;
    axis_beat_t save_beat;
    axis_beat_t shift_beat;
    logic       extra_cycle;
    logic       shift_valid;
    logic       skid_ready;
    logic       take;
    logic       pay_take;
    logic       store_word0;
    logic       store_word1;
    logic       hdr_valid_next;
    logic       runt_next;

    // no new frame while the previous header is still waiting
    assign in_ready = (state == st_idle) ? !hdr_valid :
                      (state == st_hdr)  ? 1'b1 :
                      skid_ready && !extra_cycle;
    assign shift_valid = (state == st_pay) && (extra_cycle || in_valid);
    assign take        = in_valid && in_ready;
    assign pay_take    = shift_valid && skid_ready;

    // payload moved down 6 bytes, top 2 bytes of the saved beat go first
    always_comb begin
        if (extra_cycle) begin
            shift_beat.data = {48'd0, save_beat.data[63:48]};
            shift_beat.keep = {6'd0, save_beat.keep[7:6]};
            shift_beat.last = 1'b1;
            shift_beat.user = save_beat.user;
        end else begin
            shift_beat.data = {in_beat.data[47:0], save_beat.data[63:48]};
            shift_beat.keep = {in_beat.keep[5:0], save_beat.keep[7:6]};
            shift_beat.last = in_beat.last && (in_beat.keep[7:6] == 2'b00);
            shift_beat.user = in_beat.user;
        end
    end

    always_comb begin
        state_next     = state;
        store_word0    = 1'b0;
        store_word1    = 1'b0;
        runt_next      = 1'b0;
        hdr_valid_next = hdr_valid && !hdr_ready;
        case (state)
            st_idle: begin
                if (take && in_beat.last) begin
                    runt_next = 1'b1;
                end else if (take) begin
                    store_word0 = 1'b1;
                    state_next  = st_hdr;
                end
            end
            st_hdr: begin
                // keep bit 5 clear on a closing beat means under 14 bytes
                if (take && in_beat.last && !in_beat.keep[5]) begin
                    runt_next  = 1'b1;
                    state_next = st_idle;
                end else if (take) begin
                    store_word1    = 1'b1;
                    hdr_valid_next = 1'b1;
                    state_next     = st_pay;
                end
            end
            default: begin
                if (pay_take && shift_beat.last) begin
                    state_next = st_idle;
                end
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= st_idle;
            hdr_valid   <= 1'b0;
            runt        <= 1'b0;
            busy        <= 1'b0;
            extra_cycle <= 1'b0;
        end else begin
            state     <= state_next;
            hdr_valid <= hdr_valid_next;
            runt      <= runt_next;
            busy      <= state_next != st_idle;
            // closing beat still holds bytes for one more output beat
            if (state_next == st_idle) begin
                extra_cycle <= 1'b0;
            end else if (take && in_beat.last) begin
                extra_cycle <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            save_beat <= in_beat;
        end
        if (store_word0) begin
            for (int i = 0; i < 6; i++) begin
                hdr.dest_mac[47-8*i -: 8] <= in_beat.data[8*i +: 8];
            end
            hdr.src_mac[47:40] <= in_beat.data[55:48];
            hdr.src_mac[39:32] <= in_beat.data[63:56];
        end
        if (store_word1) begin
            for (int i = 0; i < 4; i++) begin
                hdr.src_mac[31-8*i -: 8] <= in_beat.data[8*i +: 8];
            end
            hdr.eth_type <= {in_beat.data[39:32], in_beat.data[47:40]};
        end
    end

    stream_skid #(
        .payload_t (axis_beat_t)
    ) pay_skid_i (
        .clk       (clk),
        .rst       (rst),
        .in_data   (shift_beat),
        .in_valid  (shift_valid),
        .in_ready  (skid_ready),
        .out_data  (pay_beat),
        .out_valid (pay_valid),
        .out_ready (pay_ready)
    );

    hdr_hold_a: assert property (@(posedge clk) disable iff (rst)
        hdr_valid && !hdr_ready |=> $stable(hdr));

endmodule

//--- verilog/frame_distributor.sv
`timescale 1ns/10ps

module frame_distributor (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             enable,
    input  eth_rx_pkg::axis_beat_t           in_beat,
    input  logic                             in_valid,
    output logic                             in_ready,
    output eth_rx_pkg::axis_beat_t           lane_beat,
    output logic [eth_rx_pkg::num_lanes-1:0] lane_valid,
    input  logic [eth_rx_pkg::num_lanes-1:0] lane_ready
);

    import eth_rx_pkg::*;

    logic [lane_bits-1:0] cur_lane;
    logic                 in_frame;
    logic                 allow;
    logic                 take;

    // enable only matters between frames
    assign allow     = in_frame || enable;
    assign in_ready  = allow && lane_ready[cur_lane];
    assign take      = in_valid && in_ready;
    assign lane_beat = in_beat;

    always_comb begin
        lane_valid           = '0;
        lane_valid[cur_lane] = in_valid && allow;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cur_lane <= '0;
            in_frame <= 1'b0;
        end else if (take) begin
            in_frame <= !in_beat.last;
            // round robin, next lane after the closing beat
            if (in_beat.last) begin
                cur_lane <= cur_lane + 1'b1;
            end
        end
    end

endmodule

//--- verilog/stream_skid.sv
`timescale 1ns/10ps

module stream_skid #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  payload_t in_data,
    input  logic     in_valid,
    output logic     in_ready,
    output payload_t out_data,
    output logic     out_valid,
    input  logic     out_ready
);

    payload_t temp_data;
    logic     temp_valid;
    logic     out_free;
    logic     take_in;

    assign out_free = out_ready || !out_valid;
    assign take_in  = in_ready && in_valid;

    // in_ready is the registered inverse of the temp slot
    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid  <= 1'b0;
            temp_valid <= 1'b0;
            in_ready   <= 1'b0;
        end else if (out_free) begin
            out_valid  <= temp_valid || take_in;
            temp_valid <= 1'b0;
            in_ready   <= 1'b1;
        end else if (take_in) begin
            temp_valid <= 1'b1;
            in_ready   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (out_free) begin
            out_data <= temp_valid ? temp_data : in_data;
        end
        // output stalled, park the beat
        if (take_in && !out_free) begin
            temp_data <= in_data;
        end
    end

endmodule

//--- verilog/eth_rx_pkg.sv
package eth_rx_pkg;

    // parser lanes and the width of a lane index
    localparam int num_lanes     = 4;
    localparam int lane_bits     = 2;
    // pending dropped frames the merger can owe one lane
    localparam int runt_cnt_bits = 4;

    // APB register map
    localparam logic [7:0] reg_ctrl   = 8'h00;
    localparam logic [7:0] reg_frames = 8'h04;
    localparam logic [7:0] reg_runts  = 8'h08;
    localparam logic [7:0] reg_status = 8'h0C;

    // frame byte 0 travels in data[7:0]
    typedef struct packed {
        logic [63:0] data;
        logic [7:0]  keep;
        logic        last;
        logic        user;
    } axis_beat_t;

    // header fields in network order, first byte in the top bits
    typedef struct packed {
        logic [47:0] dest_mac;
        logic [47:0] src_mac;
        logic [15:0] eth_type;
    } eth_hdr_t;

endpackage
